// File: src/bridge_defines.svh
`ifndef BRIDGE_DEFINES_SVH
`define BRIDGE_DEFINES_SVH

// Byte address width on the 68000 side
// Wishbone carries bits ADDR_BITS-1 down to 2
`define ADDR_BITS 24

// Memory depth as log2 of the number of 16-bit words
// Word addresses at or above the depth are unmapped
`define RAM_WORDS_LOG2 10

// Clock cycles the memory waits after seeing the address strobe
// before it pulls DTACK low
`define RAM_WAIT_STATES 2

// Strobe cycles without DTACK before the access ends in a bus error
`define ACK_TIMEOUT 16

`endif

// File: src/wishbonePkg.sv
package wishbonePkg;

	// How a Wishbone select pattern maps onto 68000 word cycles
	// selLong   all four lanes, two word cycles
	// selHigh   lanes 3 and 2 only, bits 31:16
	// selLow    lanes 1 and 0 only, bits 15:0
	// selBad    empty or mixed patterns the 68000 cannot do
	typedef enum logic [1:0]
	{
		selLong = 2'd0,
		selHigh = 2'd1,
		selLow  = 2'd2,
		selBad  = 2'd3
	} selKind;

endpackage

// File: src/m68kBusPkg.sv
package m68kBusPkg;

	// One Wishbone data word seen either whole or as two bus words
	// half[1] is bits 31:16 and lives at the lower 68000 address
	typedef union packed
	{
		logic [31:0] longWord;
		logic [1:0][15:0] half;
	} busWord;

endpackage

// File: src/busCycleFsm.sv
module busCycleFsm (
	input  logic                clk68k,
	input  logic                reset,
	input  logic                wbCyc,
	input  logic                wbStb,
	input  wishbonePkg::selKind kind,
	input  logic                dtackN,
	input  logic                timedOut,
	output logic                asN,
	output logic                secondHalf,
	output logic                latchHalf,
	output logic                wbAck,
	output logic                wbErr
);

	typedef enum logic [2:0]
	{
		stIdle,
		stStrobe,
		stRelease,
		stGap,
		stRespond
	} stateT;

	stateT state;
	logic lastHalf;

	// Word accesses finish after one strobe, longwords after two
	assign lastHalf = (kind != wishbonePkg::selLong) || secondHalf;

	// Read half is captured on the edge that sees DTACK
	assign latchHalf = (state == stStrobe) && !dtackN;

	always_ff @(posedge clk68k)
	begin
		if (reset)
		begin
			state <= stIdle;
			asN <= 1'b1;
			secondHalf <= 1'b0;
			wbAck <= 1'b0;
			wbErr <= 1'b0;
		end
		else
		begin
			// Responses are single-cycle pulses
			wbAck <= 1'b0;
			wbErr <= 1'b0;
			case (state)
				stIdle:
					if (wbCyc && wbStb)
					begin
						secondHalf <= 1'b0;
						if (kind == wishbonePkg::selBad)
						begin
							wbErr <= 1'b1;
							state <= stRespond;
						end
						else
						begin
							asN <= 1'b0;
							state <= stStrobe;
						end
					end
				stStrobe:
					if (!dtackN)
					begin
						asN <= 1'b1;
						if (lastHalf)
						begin
							wbAck <= 1'b1;
							state <= stRespond;
						end
						else
						begin
							// Address moves to the low word while AS is high
							secondHalf <= 1'b1;
							state <= stRelease;
						end
					end
					else if (timedOut)
					begin
						asN <= 1'b1;
						wbErr <= 1'b1;
						state <= stRespond;
					end
				stRelease:
					// Memory must drop DTACK before the next strobe
					if (dtackN)
						state <= stGap;
				stGap:
				begin
					asN <= 1'b0;
					state <= stStrobe;
				end
				stRespond:
					state <= stIdle;
				default:
					state <= stIdle;
			endcase
		end
	end

endmodule

// File: src/ackTimer.sv
`include "bridge_defines.svh"

module ackTimer (
	input  logic clk68k,
	input  logic reset,
	input  logic asN,
	output logic timedOut
);

	localparam int cntBits = $clog2(`ACK_TIMEOUT + 1);

	logic [cntBits-1:0] waitCnt;

	// Counts strobe cycles and holds at the limit
	always_ff @(posedge clk68k)
	begin
		if (reset || asN)
			waitCnt <= '0;
		else if (!timedOut)
			waitCnt <= waitCnt + 1'b1;
	end

	assign timedOut = (waitCnt == cntBits'(`ACK_TIMEOUT));

endmodule

// File: src/laneSteer.sv
`include "bridge_defines.svh"

module laneSteer (
	input  logic                   clk68k,
	input  logic                   reset,
	input  logic [`ADDR_BITS-1:2]  wbAdr,
	input  logic [3:0]             wbSel,
	input  logic                   wbWe,
	input  logic [31:0]            wbDatW,
	input  logic                   secondHalf,
	input  logic                   latchHalf,
	input  logic                   asN,
	input  logic [15:0]            ramDatR,
	output wishbonePkg::selKind    kind,
	output logic [`ADDR_BITS-1:0]  m68kAddr,
	output logic                   udsN,
	output logic                   ldsN,
	output logic                   rw,
	output logic [15:0]            ramDatW,
	output logic [31:0]            wbDatR
);

	m68kBusPkg::busWord writeWord;
	m68kBusPkg::busWord laneWord;
	m68kBusPkg::busWord readWord;
	logic lowHalf;
	logic [1:0] laneSel;
	logic [15:0] laneData;

	always_comb
	begin
		if (wbSel == 4'b1111)
			kind = wishbonePkg::selLong;
		else if (wbSel[1:0] == 2'b00 && wbSel[3:2] != 2'b00)
			kind = wishbonePkg::selHigh;
		else if (wbSel[3:2] == 2'b00 && wbSel[1:0] != 2'b00)
			kind = wishbonePkg::selLow;
		else
			kind = wishbonePkg::selBad;
	end

	// Address bit 1 selects the low word of the longword
	assign lowHalf = secondHalf || (kind == wishbonePkg::selLow);
	assign m68kAddr = {wbAdr, lowHalf, 1'b0};

	// UDS is the even byte, so lane 3 or lane 1
	assign laneSel = lowHalf ? wbSel[1:0] : wbSel[3:2];
	assign udsN = asN || !laneSel[1];
	assign ldsN = asN || !laneSel[0];
	assign rw = !wbWe;

	always_comb
	begin
		writeWord.longWord = wbDatW;
		ramDatW = lowHalf ? writeWord.half[0] : writeWord.half[1];

		// Single-word reads keep only the selected lanes
		laneData = {laneSel[1] ? ramDatR[15:8] : 8'h00, laneSel[0] ? ramDatR[7:0] : 8'h00};
		laneWord.longWord = '0;
		if (lowHalf)
			laneWord.half[0] = laneData;
		else
			laneWord.half[1] = laneData;
	end

	always_ff @(posedge clk68k)
	begin
		if (reset)
			readWord.longWord <= '0;
		else if (latchHalf)
		begin
			// Longword halves fill in one after the other
			if (kind == wishbonePkg::selLong)
				readWord.half[!secondHalf] <= ramDatR;
			else
				readWord <= laneWord;
		end
	end

	assign wbDatR = readWord.longWord;

endmodule

// File: src/wordRam.sv
`include "bridge_defines.svh"

module wordRam (
	input  logic                   clk68k,
	input  logic                   reset,
	input  logic [`ADDR_BITS-1:0]  m68kAddr,
	input  logic                   asN,
	input  logic                   udsN,
	input  logic                   ldsN,
	input  logic                   rw,
	input  logic [15:0]            ramDatW,
	output logic [15:0]            ramDatR,
	output logic                   dtackN
);

	localparam int ramWords = 1 << `RAM_WORDS_LOG2;
	localparam int ackDelay = `RAM_WAIT_STATES + 1;
	localparam int waitBits = $clog2(ackDelay + 1);

	logic [15:0] mem [ramWords];
	logic [waitBits-1:0] waitCnt;
	logic [`RAM_WORDS_LOG2-1:0] wordIdx;
	logic mapped;
	logic respond;

	assign wordIdx = m68kAddr[`RAM_WORDS_LOG2:1];
	assign mapped = (m68kAddr[`ADDR_BITS-1:`RAM_WORDS_LOG2+1] == '0);

	// One transfer per strobe, once the wait states have passed
	assign respond = !asN && mapped && dtackN && (waitCnt == waitBits'(ackDelay));

	always_ff @(posedge clk68k)
	begin
		if (reset || asN)
		begin
			waitCnt <= '0;
			dtackN <= 1'b1;
		end
		else
		begin
			if (waitCnt != waitBits'(ackDelay))
				waitCnt <= waitCnt + 1'b1;
			if (respond)
				dtackN <= 1'b0;
		end
	end

	always_ff @(posedge clk68k)
	begin
		if (reset)
		begin
			// Sweep every word to zero while reset is held
			for (int i = 0; i < ramWords; i++)
				mem[i] <= '0;
		end
		else if (respond && !rw)
		begin
			if (!udsN)
				mem[wordIdx][15:8] <= ramDatW[15:8];
			if (!ldsN)
				mem[wordIdx][7:0] <= ramDatW[7:0];
		end
	end

	// Read data appears together with DTACK
	always_ff @(posedge clk68k)
	begin
		if (respond)
			ramDatR <= mem[wordIdx];
	end

endmodule

// File: src/wbTo68kBridge.sv
`include "bridge_defines.svh"

module wbTo68kBridge (
	input  logic                   clk68k,
	input  logic                   reset,
	input  logic                   wbCyc,
	input  logic                   wbStb,
	input  logic                   wbWe,
	input  logic [`ADDR_BITS-1:2]  wbAdr,
	input  logic [3:0]             wbSel,
	input  logic [31:0]            wbDatW,
	output logic [31:0]            wbDatR,
	output logic                   wbAck,
	output logic                   wbErr,
	output logic [`ADDR_BITS-1:0]  m68kAddr,
	output logic                   asN,
	output logic                   udsN,
	output logic                   ldsN,
	output logic                   rw
);

	wishbonePkg::selKind kind;
	logic dtackN;
	logic timedOut;
	logic secondHalf;
	logic latchHalf;
	logic [15:0] ramDatW;
	logic [15:0] ramDatR;

	busCycleFsm fsm_i (
		.clk68k     (clk68k),
		.reset      (reset),
		.wbCyc      (wbCyc),
		.wbStb      (wbStb),
		.kind       (kind),
		.dtackN     (dtackN),
		.timedOut   (timedOut),
		.asN        (asN),
		.secondHalf (secondHalf),
		.latchHalf  (latchHalf),
		.wbAck      (wbAck),
		.wbErr      (wbErr)
	);

	ackTimer timer_i (
		.clk68k   (clk68k),
		.reset    (reset),
		.asN      (asN),
		.timedOut (timedOut)
	);

	laneSteer steer_i (
		.clk68k     (clk68k),
		.reset      (reset),
		.wbAdr      (wbAdr),
		.wbSel      (wbSel),
		.wbWe       (wbWe),
		.wbDatW     (wbDatW),
		.secondHalf (secondHalf),
		.latchHalf  (latchHalf),
		.asN        (asN),
		.ramDatR    (ramDatR),
		.kind       (kind),
		.m68kAddr   (m68kAddr),
		.udsN       (udsN),
		.ldsN       (ldsN),
		.rw         (rw),
		.ramDatW    (ramDatW),
		.wbDatR     (wbDatR)
	);

	// Memory on the 68000 side of the bridge
	wordRam ram_i (
		.clk68k   (clk68k),
		.reset    (reset),
		.m68kAddr (m68kAddr),
		.asN      (asN),
		.udsN     (udsN),
		.ldsN     (ldsN),
		.rw       (rw),
		.ramDatW  (ramDatW),
		.ramDatR  (ramDatR),
		.dtackN   (dtackN)
	);

endmodule

// File: test/bridgeTb.sv
`include "bridge_defines.svh"

module bridgeTb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int resetCycles = 16;
	localparam int cycleLimit = 96 * (2 * `ACK_TIMEOUT + 8) + resetCycles;
	localparam int shadowBytes = 1 << (`RAM_WORDS_LOG2 + 1);
	localparam logic [3:0] legalSel [7] = '{4'hF, 4'h8, 4'h4, 4'hC, 4'h1, 4'h2, 4'h3};
	localparam logic [3:0] badSel [4] = '{4'h0, 4'h6, 4'h9, 4'h7};

	logic clk68k;
	logic reset;
	logic wbCyc;
	logic wbStb;
	logic wbWe;
	logic [`ADDR_BITS-1:2] wbAdr;
	logic [3:0] wbSel;
	logic [31:0] wbDatW;
	logic [31:0] wbDatR;
	logic wbAck;
	logic wbErr;
	logic [`ADDR_BITS-1:0] m68kAddr;
	logic asN;
	logic udsN;
	logic ldsN;
	logic rw;

	logic [15:0] lfsrState = 16'd37;
	logic [7:0] shadow [shadowBytes];
	logic [`ADDR_BITS-1:2] written [$];
	logic busy = 1'b0;
	int cycleCount = 0;

	wbTo68kBridge dut_i (.*);

	initial
	begin
		clk68k = 1'b0;
		forever #4 clk68k = ~clk68k;
	end

	task automatic reportFailure(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else reportFailure($sformatf("** Error: %s = 0x%h, expected 0x%h", name, got, exp));
	endtask

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] v;
		logic outBit;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			outBit = lfsrState[0];
			lfsrState = lfsrState >> 1;
			if (outBit)
				lfsrState = lfsrState ^ 16'hB400;
			v = {v[30:0], outBit};
		end
		return v;
	endfunction

	// Lane 3 is the lowest 68000 byte address of the longword
	function automatic logic [31:0] shadowRead(input logic [`ADDR_BITS-1:2] adr,
		input logic [3:0] sel);
		logic [31:0] v;
		v = '0;
		for (int k = 0; k < 4; k++)
			if (sel[k])
				v[8*k +: 8] = shadow[{adr, 2'b00} + 3 - k];
		return v;
	endfunction

	always @(posedge clk68k)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
			reportFailure("Run did not finish within its cycle limit");
	end

	assert property (@(posedge clk68k) disable iff (reset) !(wbAck && wbErr))
	else reportFailure("wbAck and wbErr were high in the same cycle");

	assert property (@(posedge clk68k) asN |-> (udsN && ldsN))
	else reportFailure("A data strobe was active while asN was high");

	// Any pulse outside an access is a second or stray response
	always @(posedge clk68k)
		if (!reset && !busy)
			assert (!wbAck && !wbErr)
			else reportFailure("Wishbone response seen with no access in progress");

	task automatic runAccess(input logic we, input logic [`ADDR_BITS-1:2] adr,
		input logic [3:0] sel, input logic [31:0] dat, input int expPeriods, input logic expErr);
		int periods;
		int lowCycles;
		logic prevAs;
		logic expBit1;
		logic [1:0] strobesN;
		periods = 0;
		lowCycles = 0;
		prevAs = 1'b1;
		busy = 1'b1;
		wbCyc = 1'b1;
		wbStb = 1'b1;
		wbWe = we;
		wbAdr = adr;
		wbSel = sel;
		wbDatW = dat;
		do
		begin
			@(posedge clk68k);
			if (!asN)
			begin
				if (prevAs)
					periods++;
				lowCycles++;
				// High word first for longwords
				expBit1 = (sel == 4'hF) ? (periods == 2) : (sel[3:2] == 2'b00);
				strobesN = expBit1 ? ~sel[1:0] : ~sel[3:2];
				checkValue("m68kAddr", m68kAddr, {adr, expBit1, 1'b0});
				checkValue("udsN,ldsN", {udsN, ldsN}, strobesN);
				checkValue("rw", rw, !we);
			end
			prevAs = asN;
		end
		while (!wbAck && !wbErr);
		checkValue("asN low periods", periods, expPeriods);
		checkValue("wbErr", wbErr, expErr);
		if (!we && !expErr)
			checkValue("wbDatR", wbDatR, shadowRead(adr, sel));
		// Timer limit plus one cycle for the FSM to answer
		if (expErr && expPeriods == 1)
			assert (lowCycles >= `ACK_TIMEOUT && lowCycles <= `ACK_TIMEOUT + 1)
			else reportFailure($sformatf("** Error: asN low cycles = 0x%h, expected 0x%h",
				lowCycles, `ACK_TIMEOUT));
		if (we && !expErr)
			for (int k = 0; k < 4; k++)
				if (sel[k])
					shadow[{adr, 2'b00} + 3 - k] = dat[8*k +: 8];
		#1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		busy = 1'b0;
		@(posedge clk68k);
		#1;
	endtask

	initial
	begin
		logic [`ADDR_BITS-1:2] adr;
		logic [3:0] sel;
		for (int i = 0; i < shadowBytes; i++)
			shadow[i] = 8'h00;
		reset = 1'b1;
		wbCyc = 1'b0;
		wbStb = 1'b0;
		wbWe = 1'b0;
		wbAdr = '0;
		wbSel = 4'h0;
		wbDatW = 32'h0;
		repeat (resetCycles) @(posedge clk68k);
		#1;
		reset = 1'b0;
		checkValue("asN,udsN,ldsN", {asN, udsN, ldsN}, 3'b111);
		checkValue("wbAck,wbErr", {wbAck, wbErr}, 2'b00);
		for (int i = 0; i < 40; i++)
		begin
			adr = randBits(9);
			sel = legalSel[randBits(3) % 7];
			runAccess(1'b1, adr, sel, randBits(32), (sel == 4'hF) ? 2 : 1, 1'b0);
			written.push_back(adr);
		end
		for (int i = 0; i < 40; i++)
		begin
			sel = legalSel[randBits(3) % 7];
			runAccess(1'b0, written[i], sel, 32'h0, (sel == 4'hF) ? 2 : 1, 1'b0);
		end
		// Refused writes must leave the memory alone
		for (int i = 0; i < 4; i++)
		begin
			runAccess(1'b1, written[i], badSel[i], randBits(32), 0, 1'b1);
			runAccess(1'b0, written[i], 4'hF, 32'h0, 2, 1'b0);
		end
		for (int i = 0; i < 4; i++)
		begin
			adr = randBits(21);
			adr[`ADDR_BITS-1] = 1'b1;
			runAccess(randBits(1), adr, legalSel[i], randBits(32), 1, 1'b1);
		end
		$display("Test OK");
		$finish;
	end

endmodule

// File: sim.f
+incdir+src
src/wishbonePkg.sv
src/m68kBusPkg.sv
src/busCycleFsm.sv
src/ackTimer.sv
src/laneSteer.sv
src/wordRam.sv
src/wbTo68kBridge.sv
test/bridgeTb.sv
